// ==== all.f ====
frameGenPkg.sv
frameInfoFifo.sv
frameMemory.sv
wbArbiter.sv
frameCapture.sv
frameReadout.sv
dataFrameGenerator.sv
tbDataFrameGenerator_assertions.sv
tbDataFrameGenerator.sv

// ==== dataFrameGenerator.sv ====
`timescale 1ns/1ps
module dataFrameGenerator #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                                  RD_CLK,
  input  logic                                  RD_RESETN,
  input  logic [frameGenPkg::PRE_LEN_WIDTH-1:0] preLen,
  input  frameGenPkg::sampleBeat_t              inBeat,
  input  logic                                  inValid,
  input  logic                                  outReady,
  output logic                                  inReady,
  output logic                                  outValid,
  output frameGenPkg::frameWord_t               outData
);

  frameGenPkg::wbReq_t     captureReq;   // master 0
  frameGenPkg::wbReq_t     readoutReq;   // master 1
  frameGenPkg::wbReq_t     memReq;
  frameGenPkg::wbRsp_t     captureRsp;
  frameGenPkg::wbRsp_t     readoutRsp;
  frameGenPkg::wbRsp_t     memRsp;
  frameGenPkg::frameDesc_t pushDesc;
  frameGenPkg::frameDesc_t popDesc;
  logic descPush;
  logic descPop;
  logic descFull;
  logic descEmpty;

  frameCapture #(.CHANNEL_ID(CHANNEL_ID)) i_capture (
    .RD_CLK, .RD_RESETN, .preLen, .inBeat, .inValid,
    .wbRsp(captureRsp), .descFull,
    .inReady, .wbReq(captureReq), .descPush, .desc(pushDesc)
  );

  frameReadout i_readout (
    .RD_CLK, .RD_RESETN, .descEmpty, .desc(popDesc),
    .wbRsp(readoutRsp), .outReady,
    .descPop, .wbReq(readoutReq), .outValid, .outData
  );

  wbArbiter i_arbiter (
    .RD_CLK, .RD_RESETN, .captureReq, .readoutReq, .memRsp,
    .captureRsp, .readoutRsp, .memReq
  );

  frameMemory i_memory (.RD_CLK, .RD_RESETN, .memReq, .memRsp);

  frameInfoFifo i_infoFifo (
    .RD_CLK, .RD_RESETN, .push(descPush), .pushDesc, .pop(descPop),
    .popDesc, .full(descFull), .empty(descEmpty)
  );

endmodule

// ==== frameCapture.sv ====
`timescale 1ns/1ps
module frameCapture #(
  parameter int CHANNEL_ID = 0
) (
  input  logic                                   RD_CLK,
  input  logic                                   RD_RESETN,
  input  logic [frameGenPkg::PRE_LEN_WIDTH-1:0]  preLen,
  input  frameGenPkg::sampleBeat_t               inBeat,
  input  logic                                   inValid,
  input  frameGenPkg::wbRsp_t                    wbRsp,
  input  logic                                   descFull,
  output logic                                   inReady,
  output frameGenPkg::wbReq_t                    wbReq,
  output logic                                   descPush,
  output frameGenPkg::frameDesc_t                desc
);

  frameGenPkg::captureState_t state;
  frameGenPkg::sampleBeat_t   hist [3];    // [0] newest
  frameGenPkg::sampleBeat_t   trigBeat;
  frameGenPkg::frameHeader_t  header;
  frameGenPkg::frameFooter_t  footer;
  frameGenPkg::frameWord_t    wrData;
  frameGenPkg::frameWord_t    reqDat;
  logic [frameGenPkg::MEM_ADDR_WIDTH-1:0]        reqAdr;
  logic [$clog2(frameGenPkg::SLOT_WORDS)-1:0]    wordIdx;   // word within slot
  logic [$clog2(frameGenPkg::POST_WORDS)-1:0]    postCnt;
  logic [frameGenPkg::PRE_LEN_WIDTH-1:0]         histCnt;   // saturates at 3
  logic [frameGenPkg::PRE_LEN_WIDTH-1:0]         preCount;
  logic [frameGenPkg::PRE_LEN_WIDTH-1:0]         preIdx;    // counts down, oldest first
  logic [15:0] frameNum;
  logic        slot;
  logic        readyReg;
  logic        reqValid;   // write in flight
  logic        wrStart;
  logic        wrDone;

  assign inReady  = readyReg && !(state == frameGenPkg::IDLE && descFull);  // no room, no beat
  assign wrDone   = reqValid && wbRsp.ack;
  assign descPush = (state == frameGenPkg::PUSH);
  assign desc.totalWords = 6'(preCount) + 6'(frameGenPkg::POST_WORDS + 3);
  assign wbReq = '{cyc: reqValid, stb: reqValid, we: 1'b1, adr: reqAdr, dat: reqDat};

  always_comb begin
    header.tag            = frameGenPkg::HEADER_TAG;
    header.channelId      = 8'(CHANNEL_ID);
    header.frameNumber    = frameNum;
    header.firstTimestamp = trigBeat.timestamp[frameGenPkg::HEADER_TS_WIDTH-1:0];
    header.preCount       = 3'(preCount);
    header.reserved       = '0;
    footer.tag              = frameGenPkg::FOOTER_TAG;
    footer.dataWords        = 8'(preCount) + 8'(frameGenPkg::POST_WORDS + 1);
    footer.triggerTimestamp = trigBeat.timestamp;
  end

  // next word to write, picked by state
  always_comb begin
    case (state)
      frameGenPkg::HEADER: wrData = header;
      frameGenPkg::PRE:    wrData = hist[preIdx].samples;
      frameGenPkg::TRIG:   wrData = trigBeat.samples;
      frameGenPkg::FOOTER: wrData = footer;
      default:             wrData = inBeat.samples;  // post beats go straight through
    endcase
    wrStart = !reqValid &&
      ((state inside {frameGenPkg::HEADER, frameGenPkg::PRE, frameGenPkg::TRIG,
                      frameGenPkg::FOOTER}) ||
       (state == frameGenPkg::POST && inValid && readyReg));
  end

  // payload regs
  always_ff @(posedge RD_CLK) begin
    if (wrStart) begin
      reqAdr <= {slot, wordIdx};
      reqDat <= wrData;
    end
    if (state == frameGenPkg::IDLE && inValid && inReady) begin
      if (inBeat.trigger) trigBeat <= inBeat;
      else begin
        hist[2] <= hist[1];  // shift history
        hist[1] <= hist[0];
        hist[0] <= inBeat;
      end
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      state    <= frameGenPkg::IDLE;
      readyReg <= 1'b0;
      reqValid <= 1'b0;
      histCnt  <= '0;
      preCount <= '0;
      preIdx   <= '0;
      postCnt  <= '0;
      wordIdx  <= '0;
      frameNum <= '0;
      slot     <= 1'b0;
    end else begin
      if (wrStart) reqValid <= 1'b1;
      if (wrDone) begin
        reqValid <= 1'b0;        // cyc low for a cycle
        wordIdx  <= wordIdx + 1'b1;
      end
      case (state)
        frameGenPkg::IDLE: begin
          readyReg <= 1'b1;
          if (inValid && inReady) begin
            if (inBeat.trigger) begin
              preCount <= (preLen < histCnt) ? preLen : histCnt;
              readyReg <= 1'b0;
              wordIdx  <= '0;
              state    <= frameGenPkg::HEADER;
            end else if (histCnt != 2'd3) begin
              histCnt <= histCnt + 1'b1;
            end
          end
        end
        frameGenPkg::HEADER: if (wrDone) begin
          preIdx <= preCount - 1'b1;
          state  <= (preCount == '0) ? frameGenPkg::TRIG : frameGenPkg::PRE;
        end
        frameGenPkg::PRE: if (wrDone) begin
          if (preIdx == '0) state <= frameGenPkg::TRIG;
          else preIdx <= preIdx - 1'b1;
        end
        frameGenPkg::TRIG: if (wrDone) begin
          postCnt  <= '0;
          readyReg <= 1'b1;  // open for first post beat
          state    <= frameGenPkg::POST;
        end
        frameGenPkg::POST: begin
          if (wrStart) readyReg <= 1'b0;  // beat taken, hold off until written
          if (wrDone) begin
            if (postCnt == 4'(frameGenPkg::POST_WORDS - 1)) state <= frameGenPkg::FOOTER;
            else begin
              postCnt  <= postCnt + 1'b1;
              readyReg <= 1'b1;
            end
          end
        end
        frameGenPkg::FOOTER: if (wrDone) state <= frameGenPkg::PUSH;
        default: begin  // PUSH, descriptor goes out this cycle
          slot     <= ~slot;
          frameNum <= frameNum + 1'b1;
          histCnt  <= '0;  // fresh pre-acq window
          readyReg <= 1'b1;
          state    <= frameGenPkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== frameGenPkg.sv ====
package frameGenPkg;

  localparam int WORD_WIDTH      = 64;
  localparam int SAMPLE_WIDTH    = 16;  // 12-bit adc, sign-extended upstream
  localparam int TIMESTAMP_WIDTH = 48;
  localparam int HEADER_TS_WIDTH = 24;  // low timestamp bits in header
  localparam int PRE_LEN_WIDTH   = 2;   // up to 3 pre-trigger beats
  localparam int POST_WORDS      = 12;  // data words after trigger beat
  localparam int SLOT_WORDS      = 32;  // words per frame slot
  localparam int MEM_ADDR_WIDTH  = 6;   // two slots

  localparam logic [7:0] HEADER_TAG = 8'hA5;
  localparam logic [7:0] FOOTER_TAG = 8'h5A;

  typedef logic [WORD_WIDTH-1:0] frameWord_t;

  // one adc beat, samples go to memory as one word
  typedef struct packed {
    logic [3:0][SAMPLE_WIDTH-1:0] samples;
    logic [TIMESTAMP_WIDTH-1:0]   timestamp;
    logic                         trigger;
  } sampleBeat_t;

  typedef struct packed {
    logic [7:0]                 tag;
    logic [7:0]                 channelId;
    logic [15:0]                frameNumber;
    logic [HEADER_TS_WIDTH-1:0] firstTimestamp;
    logic [2:0]                 preCount;
    logic [4:0]                 reserved;  // always zero
  } frameHeader_t;

  typedef struct packed {
    logic [7:0]                 tag;
    logic [7:0]                 dataWords;         // pre + trigger + post
    logic [TIMESTAMP_WIDTH-1:0] triggerTimestamp;
  } frameFooter_t;

  // header + data + footer
  typedef struct packed {
    logic [5:0] totalWords;
  } frameDesc_t;

  // wishbone classic, master side
  typedef struct packed {
    logic                      cyc;
    logic                      stb;
    logic                      we;
    logic [MEM_ADDR_WIDTH-1:0] adr;
    frameWord_t                dat;
  } wbReq_t;

  // wishbone classic, slave side
  typedef struct packed {
    logic       ack;
    frameWord_t dat;
  } wbRsp_t;

  typedef enum logic [2:0] {IDLE, HEADER, PRE, TRIG, POST, FOOTER, PUSH} captureState_t;

  typedef enum logic [1:0] {WAIT, FETCH, PRESENT, DONE} readoutState_t;

endpackage

// ==== frameInfoFifo.sv ====
`timescale 1ns/1ps
module frameInfoFifo (
  input  logic                    RD_CLK,
  input  logic                    RD_RESETN,
  input  logic                    push,
  input  frameGenPkg::frameDesc_t pushDesc,
  input  logic                    pop,
  output frameGenPkg::frameDesc_t popDesc,
  output logic                    full,
  output logic                    empty
);

  frameGenPkg::frameDesc_t entries [2];  // one per memory slot
  logic       wrPtr;
  logic       rdPtr;
  logic [1:0] count;
  logic       doPush;
  logic       doPop;

  assign doPush  = push && !full;  // guard, capture checks full anyway
  assign doPop   = pop && !empty;
  assign full    = (count == 2'd2);
  assign empty   = (count == 2'd0);
  assign popDesc = entries[rdPtr];  // head, stable until pop

  always_ff @(posedge RD_CLK) begin
    if (doPush) entries[wrPtr] <= pushDesc;
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      wrPtr <= 1'b0;
      rdPtr <= 1'b0;
      count <= '0;
    end else begin
      if (doPush) wrPtr <= ~wrPtr;
      if (doPop)  rdPtr <= ~rdPtr;
      count <= count + 2'(doPush) - 2'(doPop);
    end
  end

endmodule

// ==== frameMemory.sv ====
`timescale 1ns/1ps
module frameMemory (
  input  logic                RD_CLK,
  input  logic                RD_RESETN,
  input  frameGenPkg::wbReq_t memReq,
  output frameGenPkg::wbRsp_t memRsp
);

  frameGenPkg::frameWord_t mem [2**frameGenPkg::MEM_ADDR_WIDTH];  // two frame slots
  frameGenPkg::frameWord_t rdData;
  logic                    ackReg;
  logic                    strobe;

  // new access only when not already acking
  assign strobe = memReq.cyc && memReq.stb && !ackReg;

  always_ff @(posedge RD_CLK) begin
    if (strobe) begin
      if (memReq.we) mem[memReq.adr] <= memReq.dat;
      rdData <= mem[memReq.adr];  // valid alongside ack
    end
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) ackReg <= 1'b0;
    else            ackReg <= strobe;  // single-cycle ack
  end

  assign memRsp = '{ack: ackReg, dat: rdData};

endmodule

// ==== frameReadout.sv ====
`timescale 1ns/1ps
module frameReadout (
  input  logic                    RD_CLK,
  input  logic                    RD_RESETN,
  input  logic                    descEmpty,
  input  frameGenPkg::frameDesc_t desc,
  input  frameGenPkg::wbRsp_t     wbRsp,
  input  logic                    outReady,
  output logic                    descPop,
  output frameGenPkg::wbReq_t     wbReq,
  output logic                    outValid,
  output frameGenPkg::frameWord_t outData
);

  frameGenPkg::readoutState_t state;
  logic [$clog2(frameGenPkg::SLOT_WORDS)-1:0] wordIdx;
  logic                                       slot;      // own toggle, follows capture
  logic                                       reqValid;  // read in flight
  logic                                       lastWord;

  assign descPop  = (state == frameGenPkg::DONE);
  assign lastWord = (6'(wordIdx) == desc.totalWords - 1'b1);
  // reads only, dat unused by slave
  assign wbReq = '{cyc: reqValid, stb: reqValid, we: 1'b0, adr: {slot, wordIdx}, dat: '0};

  // output word, held until handshake
  always_ff @(posedge RD_CLK) begin
    if (state == frameGenPkg::FETCH && reqValid && wbRsp.ack) outData <= wbRsp.dat;
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      state    <= frameGenPkg::WAIT;
      wordIdx  <= '0;
      slot     <= 1'b0;
      reqValid <= 1'b0;
      outValid <= 1'b0;
    end else begin
      case (state)
        frameGenPkg::WAIT: begin
          wordIdx <= '0;
          if (!descEmpty) state <= frameGenPkg::FETCH;  // a frame is complete
        end
        frameGenPkg::FETCH: begin
          if (!reqValid) reqValid <= 1'b1;
          else if (wbRsp.ack) begin
            reqValid <= 1'b0;
            outValid <= 1'b1;
            state    <= frameGenPkg::PRESENT;
          end
        end
        frameGenPkg::PRESENT: begin
          if (outReady) begin
            outValid <= 1'b0;
            if (lastWord) state <= frameGenPkg::DONE;
            else begin
              wordIdx <= wordIdx + 1'b1;
              state   <= frameGenPkg::FETCH;
            end
          end
        end
        default: begin  // DONE, pop and move on
          slot  <= ~slot;
          state <= frameGenPkg::WAIT;
        end
      endcase
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator in timing mode, run, then look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tbDataFrameGenerator -f all.f -o tbSim &&
  ./obj_dir/tbSim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }

// ==== tbDataFrameGenerator.sv ====
`timescale 1ns/1ps
module tbDataFrameGenerator;

  localparam int MAX_WAIT = 2000;  // cycles per wait loop

  logic                                  RD_CLK;
  logic                                  RD_RESETN;
  logic [frameGenPkg::PRE_LEN_WIDTH-1:0] preLen;
  frameGenPkg::sampleBeat_t              inBeat;
  logic                                  inValid;
  logic                                  outReady;
  logic                                  inReady;
  logic                                  outValid;
  frameGenPkg::frameWord_t               outData;

  integer      seed;
  logic [47:0] nextTs;     // timestamp of the next generated beat
  bit          useGaps;    // random outReady gaps
  int          errCount;
  int          timeoutCount;

  // reference model, fed only by beats the DUT took
  frameGenPkg::sampleBeat_t  acceptedBeats [$];
  logic [1:0]                acceptedPreLen [$];
  frameGenPkg::sampleBeat_t  history [$];     // newest at the back
  frameGenPkg::frameWord_t   refData [$];     // pre, trigger, post samples
  frameGenPkg::frameHeader_t refHeader;
  frameGenPkg::frameFooter_t refFooter;
  int                        scanIdx;
  logic [15:0]               refFrameNum;

  dataFrameGenerator #(.CHANNEL_ID(7)) i_dut (
    .RD_CLK, .RD_RESETN, .preLen, .inBeat, .inValid, .outReady,
    .inReady, .outValid, .outData
  );

  always #50 RD_CLK = ~RD_CLK;

  task automatic reportMismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
    errCount++;
    $display("Mismatch at %0t: %s expected %0h, got %0h", $time, name, exp, act);
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (act !== exp) reportMismatch(name, 64'(exp), 64'(act));
  endtask

  task automatic checkWord(input string name, input frameGenPkg::frameWord_t exp,
                           input frameGenPkg::frameWord_t act);
    if (act !== exp) reportMismatch(name, exp, act);
  endtask

  task automatic checkHeader(input frameGenPkg::frameHeader_t exp,
                             input frameGenPkg::frameHeader_t act);
    if (act.tag !== exp.tag) reportMismatch("header tag", 64'(exp.tag), 64'(act.tag));
    if (act.channelId !== exp.channelId)
      reportMismatch("header channelId", 64'(exp.channelId), 64'(act.channelId));
    if (act.frameNumber !== exp.frameNumber)
      reportMismatch("header frameNumber", 64'(exp.frameNumber), 64'(act.frameNumber));
    if (act.firstTimestamp !== exp.firstTimestamp)
      reportMismatch("header firstTimestamp", 64'(exp.firstTimestamp), 64'(act.firstTimestamp));
    if (act.preCount !== exp.preCount)
      reportMismatch("header preCount", 64'(exp.preCount), 64'(act.preCount));
    if (act.reserved !== exp.reserved)
      reportMismatch("header reserved", 64'(exp.reserved), 64'(act.reserved));
  endtask

  task automatic checkFooter(input frameGenPkg::frameFooter_t exp,
                             input frameGenPkg::frameFooter_t act);
    if (act.tag !== exp.tag) reportMismatch("footer tag", 64'(exp.tag), 64'(act.tag));
    if (act.dataWords !== exp.dataWords)
      reportMismatch("footer dataWords", 64'(exp.dataWords), 64'(act.dataWords));
    if (act.triggerTimestamp !== exp.triggerTimestamp)
      reportMismatch("footer triggerTimestamp", 64'(exp.triggerTimestamp),
                     64'(act.triggerTimestamp));
  endtask

  function automatic frameGenPkg::sampleBeat_t makeBeat(input logic trig);
    frameGenPkg::sampleBeat_t beat;
    logic [11:0]              adc;
    int                       k;
    for (k = 0; k < 4; k++) begin
      adc = 12'($random(seed));
      beat.samples[k] = {{4{adc[11]}}, adc};  // sign-extend like the adc source
    end
    beat.timestamp = nextTs;
    beat.trigger   = trig;
    nextTs = nextTs + 48'd4;
    return beat;
  endfunction

  // called on a falling edge, returns on the falling edge after the transfer
  task automatic sendBeat(input frameGenPkg::sampleBeat_t beat);
    int waitCnt;
    inBeat  = beat;
    inValid = 1'b1;
    waitCnt = 0;
    while (!inReady && waitCnt < MAX_WAIT) begin
      @(negedge RD_CLK);
      waitCnt++;
    end
    if (inReady) begin
      acceptedBeats.push_back(beat);
      acceptedPreLen.push_back(preLen);
    end else begin
      timeoutCount++;
      $display("Error at %0t: inReady never rose, beat was not taken", $time);
    end
    @(negedge RD_CLK);
    inValid = 1'b0;
  endtask

  task automatic sendFrame(input int lead, input bit postTrig);
    int i;
    for (i = 0; i < lead; i++) sendBeat(makeBeat(1'b0));
    sendBeat(makeBeat(1'b1));
    for (i = 0; i < frameGenPkg::POST_WORDS; i++)
      sendBeat(makeBeat(postTrig && (i % 3 == 1)));  // flags inside the post window
  endtask

  task automatic collectWord(output frameGenPkg::frameWord_t word, output bit ok);
    int waitCnt;
    if (useGaps) begin
      outReady = 1'b0;
      repeat ($unsigned($random(seed)) % 4) @(negedge RD_CLK);
    end
    outReady = 1'b1;
    waitCnt  = 0;
    while (!outValid && waitCnt < MAX_WAIT) begin
      @(negedge RD_CLK);
      waitCnt++;
    end
    ok   = outValid;
    word = outData;
    if (!ok) begin
      timeoutCount++;
      $display("Error at %0t: no output word arrived in time", $time);
    end
    @(negedge RD_CLK);  // word taken on the rising edge before
  endtask

  // next frame from the record of accepted beats
  function automatic bit buildReference();
    frameGenPkg::sampleBeat_t beat;
    logic [1:0]               trigPreLen;
    int                       preCount;
    int                       i;
    bit                       found;
    found = 1'b0;
    refData.delete();
    while (!found && scanIdx < acceptedBeats.size()) begin
      beat       = acceptedBeats[scanIdx];
      trigPreLen = acceptedPreLen[scanIdx];
      scanIdx++;
      if (beat.trigger) found = 1'b1;
      else begin
        history.push_back(beat);
        if (history.size() > 3) void'(history.pop_front());
      end
    end
    if (!found || scanIdx + frameGenPkg::POST_WORDS > acceptedBeats.size()) return 1'b0;
    preCount = (int'(trigPreLen) < history.size()) ? int'(trigPreLen) : history.size();
    for (i = history.size() - preCount; i < history.size(); i++)
      refData.push_back(history[i].samples);  // oldest first
    refData.push_back(beat.samples);
    for (i = 0; i < frameGenPkg::POST_WORDS; i++)
      refData.push_back(acceptedBeats[scanIdx + i].samples);
    scanIdx += frameGenPkg::POST_WORDS;
    history.delete();  // fresh pre-acq window after each frame
    refHeader = '{tag: frameGenPkg::HEADER_TAG, channelId: 8'd7, frameNumber: refFrameNum,
                  firstTimestamp: beat.timestamp[23:0], preCount: 3'(preCount), reserved: 5'd0};
    refFooter = '{tag: frameGenPkg::FOOTER_TAG,
                  dataWords: 8'(preCount + frameGenPkg::POST_WORDS + 1),
                  triggerTimestamp: beat.timestamp};
    refFrameNum++;
    return 1'b1;
  endfunction

  task automatic expectFrame();
    frameGenPkg::frameWord_t got;
    bit                      ok;
    int                      i;
    collectWord(got, ok);
    if (!ok) return;
    // a frame leaves only after all its beats went in
    if (!buildReference()) begin
      errCount++;
      $display("Error at %0t: frame came out with no complete trigger in the sent beats", $time);
      return;
    end
    checkHeader(refHeader, got);
    for (i = 0; i < refData.size(); i++) begin
      collectWord(got, ok);
      if (!ok) return;
      checkWord($sformatf("frame %0d word %0d", refHeader.frameNumber, i + 1), refData[i], got);
    end
    collectWord(got, ok);
    if (ok) checkFooter(refFooter, got);
  endtask

  task automatic idleAfterReset();
    repeat (20) begin
      checkBit("inReady", 1'b1, inReady);
      checkBit("outValid", 1'b0, outValid);
      @(negedge RD_CLK);
    end
  endtask

  task automatic frameWithoutPre();
    preLen = 2'd0;
    sendFrame(5, 1'b0);
    expectFrame();
  endtask

  task automatic frameWithPre();
    preLen = 2'd3;
    sendFrame(4, 1'b0);
    expectFrame();
    sendFrame(1, 1'b0);  // one beat after the frame, preCount 1
    expectFrame();
  endtask

  task automatic postWindowTriggers();
    preLen = 2'd1;
    sendFrame(2, 1'b1);
    expectFrame();
    repeat (40) begin  // capture must be idle, nothing more out
      checkBit("inReady", 1'b1, inReady);
      checkBit("outValid", 1'b0, outValid);
      @(negedge RD_CLK);
    end
    sendFrame(0, 1'b0);
    expectFrame();
  endtask

  task automatic backPressure();
    frameGenPkg::sampleBeat_t third;
    outReady = 1'b0;
    preLen   = 2'd2;
    sendFrame(3, 1'b0);
    sendFrame(2, 1'b0);
    third   = makeBeat(1'b1);
    inBeat  = third;
    inValid = 1'b1;
    repeat (50) begin  // both slots busy
      checkBit("inReady with queue full", 1'b0, inReady);
      @(negedge RD_CLK);
    end
    useGaps = 1'b1;
    fork
      begin
        sendBeat(third);
        repeat (frameGenPkg::POST_WORDS) sendBeat(makeBeat(1'b0));
      end
      repeat (3) expectFrame();
    join
  endtask

  initial begin
    RD_CLK       = 1'b0;
    RD_RESETN    = 1'b0;
    preLen       = '0;
    inBeat       = '0;
    inValid      = 1'b0;
    outReady     = 1'b0;
    seed         = 32'h2582_a43e;
    nextTs       = 48'h3c_5a00_0100;  // upper bits set, header and footer differ
    useGaps      = 1'b0;
    errCount     = 0;
    timeoutCount = 0;
    scanIdx      = 0;
    refFrameNum  = '0;
    repeat (4) @(negedge RD_CLK);
    RD_RESETN = 1'b1;
    @(negedge RD_CLK);
    idleAfterReset();
    frameWithoutPre();
    frameWithPre();
    postWindowTriggers();
    backPressure();
    $display("%0d errors, %0d timeouts", errCount, timeoutCount);
    if (errCount == 0 && timeoutCount == 0) $display("PASS: all tests");
    else $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== tbDataFrameGenerator_assertions.sv ====
`timescale 1ns/1ps
module tbDataFrameGenerator_assertions (
  input logic                    RD_CLK,
  input logic                    RD_RESETN,
  input logic                    valid,
  input logic                    ready,
  input frameGenPkg::frameWord_t data,
  input logic                    cyc,
  input logic                    stb,
  input logic                    ack
);

  // word held until taken
  outputHold: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    valid && !ready |=> valid && $stable(data))
    else $error("word changed or was dropped before it was taken");

  ackInCycle: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    ack |-> cyc && stb)
    else $error("ack without cyc and stb");

  ackSingle: assert property (@(posedge RD_CLK) disable iff (!RD_RESETN)
    ack |=> !ack)
    else $error("ack lasted two cycles");

endmodule

// readout side, output handshake plus master-1 bus view
bind frameReadout tbDataFrameGenerator_assertions i_readoutChecks (
  .RD_CLK, .RD_RESETN, .valid(outValid), .ready(outReady), .data(outData),
  .cyc(wbReq.cyc), .stb(wbReq.stb), .ack(wbRsp.ack)
);

// slave side, granted request must hold its write data until ack
bind frameMemory tbDataFrameGenerator_assertions i_memoryChecks (
  .RD_CLK, .RD_RESETN, .valid(memReq.cyc && memReq.stb), .ready(memRsp.ack),
  .data(memReq.dat), .cyc(memReq.cyc), .stb(memReq.stb), .ack(memRsp.ack)
);

// ==== wbArbiter.sv ====
`timescale 1ns/1ps
module wbArbiter (
  input  logic                RD_CLK,
  input  logic                RD_RESETN,
  input  frameGenPkg::wbReq_t captureReq,
  input  frameGenPkg::wbReq_t readoutReq,
  input  frameGenPkg::wbRsp_t memRsp,
  output frameGenPkg::wbRsp_t captureRsp,
  output frameGenPkg::wbRsp_t readoutRsp,
  output frameGenPkg::wbReq_t memReq
);

  logic grant;       // 0 capture, 1 readout
  logic lastServed;  // master that got the last ack
  logic grantedCyc;
  logic pick;
  logic sel;         // master routed this cycle

  always_comb begin
    grantedCyc = grant ? readoutReq.cyc : captureReq.cyc;
    if (captureReq.cyc && readoutReq.cyc) pick = ~lastServed;  // contested, other one
    else if (readoutReq.cyc)              pick = 1'b1;
    else if (captureReq.cyc)              pick = 1'b0;
    else                                  pick = grant;
    // hold while the owner is mid-cycle, else switch right away
    sel = grantedCyc ? grant : pick;
  end

  always_ff @(posedge RD_CLK) begin
    if (!RD_RESETN) begin
      grant      <= 1'b0;
      lastServed <= 1'b1;  // capture wins first tie
    end else begin
      grant <= sel;
      if (memRsp.ack) lastServed <= sel;
    end
  end

  assign memReq = sel ? readoutReq : captureReq;

  // ack only to the owner, data fanned out
  assign captureRsp = '{ack: memRsp.ack & ~sel, dat: memRsp.dat};
  assign readoutRsp = '{ack: memRsp.ack & sel, dat: memRsp.dat};

endmodule
